// File: logic/mips_pkg.sv
package mips_pkg;

  localparam int word_w = 32; // data and address width

  // major opcode, bits 31:26
  localparam logic [5:0] op_special = 6'h00; // register format, decode funct
  localparam logic [5:0] op_j       = 6'h02;
  localparam logic [5:0] op_beq     = 6'h04;
  localparam logic [5:0] op_bne     = 6'h05;
  localparam logic [5:0] op_addiu   = 6'h09;
  localparam logic [5:0] op_ori     = 6'h0d;
  localparam logic [5:0] op_lui     = 6'h0f;
  localparam logic [5:0] op_lw      = 6'h23;
  localparam logic [5:0] op_sw      = 6'h2b;

  // funct field for op_special
  localparam logic [5:0] fn_jr   = 6'h08;
  localparam logic [5:0] fn_addu = 6'h21;
  localparam logic [5:0] fn_subu = 6'h23;
  localparam logic [5:0] fn_and  = 6'h24;
  localparam logic [5:0] fn_or   = 6'h25;
  localparam logic [5:0] fn_slt  = 6'h2a;

  typedef struct packed {
    logic [5:0] op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;    // destination for register format
    logic [4:0] shamt; // no shifts supported, ignored
    logic [5:0] funct;
  } r_fmt_t;

  typedef struct packed {
    logic [5:0]  op;
    logic [4:0]  rs;
    logic [4:0]  rt;  // destination for immediate format
    logic [15:0] imm;
  } i_fmt_t;

  typedef struct packed {
    logic [5:0]  op;
    logic [25:0] target; // word index within the current 256 MB region
  } j_fmt_t;

  // same 32 bits, three views
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    j_fmt_t j_fmt;
  } instr_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt,
    alu_lui
  } alu_op_t;

  // decoded control, controller -> datapath
  typedef struct packed {
    logic    reg_write;    // register file write wanted
    logic    reg_dst_rd;   // rd, else rt
    logic    alu_src_imm;  // operand b from immediate
    logic    imm_zero_ext; // ori style extension
    logic    mem_to_reg;   // write back loaded word
    logic    branch_eq;
    logic    branch_ne;
    logic    branch_taken; // resolved in controller from zero
    logic    jump;         // j target
    logic    jump_reg;     // jr, next pc from rs
    alu_op_t alu_op;
  } ctrl_t;

endpackage

// File: logic/alu.sv
`timescale 1ns/1ns

module alu (
  input  logic [mips_pkg::word_w-1:0] a,    // rs
  input  logic [mips_pkg::word_w-1:0] b,    // rt or extended immediate
  input  mips_pkg::alu_op_t           op,
  output logic [mips_pkg::word_w-1:0] y,
  output logic                        zero
);

  always_comb begin
    case (op)
      mips_pkg::alu_add: y = a + b; // addu, addiu, address calc
      mips_pkg::alu_sub: y = a - b; // subu, branch compare
      mips_pkg::alu_and: y = a & b;
      mips_pkg::alu_or:  y = a | b;
      mips_pkg::alu_slt: begin
        // signed compare, result 0 or 1
        y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      end
      mips_pkg::alu_lui: y = b << 16; // imm into upper half
      default:           y = '0;
    endcase
  end

  assign zero = (y == '0); // beq/bne after alu_sub

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ns

module reg_file (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic [4:0]                  ra,   // rs port
  input  logic [4:0]                  rb,   // rt port
  input  logic [4:0]                  wa,
  input  logic [mips_pkg::word_w-1:0] wd,
  input  logic                        we,   // already gated by commit
  output logic [mips_pkg::word_w-1:0] rd_a,
  output logic [mips_pkg::word_w-1:0] rd_b,
  output logic [mips_pkg::word_w-1:0] v0    // register 2 tap
);

  logic [mips_pkg::word_w-1:0] regs [32];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != 5'd0) begin // $zero never written
      regs[wa] <= wd;
    end
  end

  // combinational reads, new value visible after the edge
  assign rd_a = regs[ra];
  assign rd_b = regs[rb];
  assign v0   = regs[2];

endmodule

// File: logic/controller.sv
`timescale 1ns/1ns

module controller (
  input  mips_pkg::instr_t instr,
  input  logic             zero,   // from alu, after subtract for branches
  input  logic             commit, // strobes only on a committing cycle
  output mips_pkg::ctrl_t  ctrl,
  output logic             data_write,
  output logic             data_read
);

  mips_pkg::ctrl_t dec; // decode before branch resolution

  always_comb begin
    dec        = '0;                // unknown opcode: no-op, nothing written
    dec.alu_op = mips_pkg::alu_add;
    case (instr.r_fmt.op)
      mips_pkg::op_special: begin
        dec.reg_dst_rd = 1'b1;
        case (instr.r_fmt.funct)
          mips_pkg::fn_addu: begin
            dec.reg_write = 1'b1;
          end
          mips_pkg::fn_subu: begin
            dec.reg_write = 1'b1;
            dec.alu_op    = mips_pkg::alu_sub;
          end
          mips_pkg::fn_and: begin
            dec.reg_write = 1'b1;
            dec.alu_op    = mips_pkg::alu_and;
          end
          mips_pkg::fn_or: begin
            dec.reg_write = 1'b1;
            dec.alu_op    = mips_pkg::alu_or;
          end
          mips_pkg::fn_slt: begin
            dec.reg_write = 1'b1;
            dec.alu_op    = mips_pkg::alu_slt;
          end
          mips_pkg::fn_jr: dec.jump_reg = 1'b1; // no register write
          default: ;                            // unsupported funct
        endcase
      end
      mips_pkg::op_j:   dec.jump = 1'b1;
      mips_pkg::op_beq: begin
        dec.branch_eq = 1'b1;
        dec.alu_op    = mips_pkg::alu_sub; // rs - rt, zero when equal
      end
      mips_pkg::op_bne: begin
        dec.branch_ne = 1'b1;
        dec.alu_op    = mips_pkg::alu_sub;
      end
      mips_pkg::op_addiu: begin
        dec.reg_write   = 1'b1;
        dec.alu_src_imm = 1'b1;
      end
      mips_pkg::op_ori: begin
        dec.reg_write    = 1'b1;
        dec.alu_src_imm  = 1'b1;
        dec.imm_zero_ext = 1'b1; // logical immediate
        dec.alu_op       = mips_pkg::alu_or;
      end
      mips_pkg::op_lui: begin
        dec.reg_write    = 1'b1;
        dec.alu_src_imm  = 1'b1;
        dec.imm_zero_ext = 1'b1;
        dec.alu_op       = mips_pkg::alu_lui;
      end
      mips_pkg::op_lw: begin
        dec.reg_write   = 1'b1;
        dec.alu_src_imm = 1'b1; // base + offset
        dec.mem_to_reg  = 1'b1;
      end
      mips_pkg::op_sw:  dec.alu_src_imm = 1'b1;
      default: ;
    endcase
  end

  always_comb begin
    ctrl              = dec;
    ctrl.branch_taken = (dec.branch_eq & zero) | (dec.branch_ne & ~zero);
  end

  // strobes held low on stall and once inactive
  assign data_write = commit & (instr.i_fmt.op == mips_pkg::op_sw);
  assign data_read  = commit & (instr.i_fmt.op == mips_pkg::op_lw);

endmodule

// File: logic/datapath.sv
`timescale 1ns/1ns

module datapath #(
  parameter logic [31:0] reset_vector = 32'hbfc0_0000
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             clk_enable,
  input  mips_pkg::instr_t instr,
  input  mips_pkg::ctrl_t  ctrl,
  input  logic [31:0]      data_readdata,
  output logic             zero,
  output logic             commit,
  output logic             active,
  output logic [31:0]      instr_address,
  output logic [31:0]      data_address,
  output logic [31:0]      data_writedata,
  output logic [31:0]      register_v0
);

  logic [mips_pkg::word_w-1:0] pc;
  logic [mips_pkg::word_w-1:0] pc_plus4;
  logic [mips_pkg::word_w-1:0] pc_next;
  logic [mips_pkg::word_w-1:0] sext_imm; // branch offset and arithmetic immediate
  logic [mips_pkg::word_w-1:0] imm_ext;  // operand b when alu_src_imm
  logic [mips_pkg::word_w-1:0] rs_val;
  logic [mips_pkg::word_w-1:0] rt_val;
  logic [mips_pkg::word_w-1:0] alu_y;
  logic [mips_pkg::word_w-1:0] wb_data;
  logic [4:0]                  wb_addr;

  assign commit   = active & clk_enable; // single place for the commit condition
  assign pc_plus4 = pc + 32'd4;
  assign sext_imm = {{16{instr.i_fmt.imm[15]}}, instr.i_fmt.imm};
  assign imm_ext  = ctrl.imm_zero_ext ? {16'h0000, instr.i_fmt.imm} : sext_imm;

  // no delay slot, target applies to the next instruction
  always_comb begin
    if (ctrl.jump_reg) pc_next = rs_val;
    else if (ctrl.jump) pc_next = {pc_plus4[31:28], instr.j_fmt.target, 2'b00};
    else if (ctrl.branch_taken) pc_next = pc_plus4 + {sext_imm[29:0], 2'b00};
    else pc_next = pc_plus4;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc     <= reset_vector;
      active <= 1'b1;
    end else if (commit) begin
      pc <= pc_next;
      if (pc_next == '0) active <= 1'b0; // jump to 0 ends the program
    end
  end

  assign wb_addr = ctrl.reg_dst_rd ? instr.r_fmt.rd : instr.i_fmt.rt;
  assign wb_data = ctrl.mem_to_reg ? data_readdata : alu_y; // lw returns loaded word

  reg_file u_reg_file (
    .clk    (clk),
    .arst_n (arst_n),
    .ra     (instr.r_fmt.rs),
    .rb     (instr.r_fmt.rt),
    .wa     (wb_addr),
    .wd     (wb_data),
    .we     (ctrl.reg_write & commit), // no write on stall
    .rd_a   (rs_val),
    .rd_b   (rt_val),
    .v0     (register_v0)
  );

  alu u_alu (
    .a    (rs_val),
    .b    (ctrl.alu_src_imm ? imm_ext : rt_val),
    .op   (ctrl.alu_op),
    .y    (alu_y),
    .zero (zero)
  );

  assign instr_address  = pc;
  assign data_address   = alu_y;  // base + offset for lw/sw
  assign data_writedata = rt_val; // sw stores rt

endmodule

// File: logic/mips_cpu_harvard.sv
`timescale 1ns/1ns

module mips_cpu_harvard #(
  parameter logic [31:0] reset_vector = 32'hbfc0_0000
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        clk_enable,     // stall when low
  output logic        active,         // falls after jump to 0
  output logic [31:0] register_v0,

  output logic [31:0] instr_address,  // current pc
  input  logic [31:0] instr_readdata, // combinational fetch

  output logic [31:0] data_address,
  output logic        data_write,
  output logic        data_read,
  output logic [31:0] data_writedata,
  input  logic [31:0] data_readdata
);

  mips_pkg::instr_t instr; // fetched word, three decodings
  mips_pkg::ctrl_t  ctrl;
  logic             zero;   // alu result zero, for beq/bne
  logic             commit; // active and clk_enable

  assign instr = mips_pkg::instr_t'(instr_readdata);

  controller u_controller (
    .instr      (instr),
    .zero       (zero),
    .commit     (commit),
    .ctrl       (ctrl),
    .data_write (data_write),
    .data_read  (data_read)
  );

  datapath #(
    .reset_vector (reset_vector)
  ) u_datapath (
    .clk            (clk),
    .arst_n         (arst_n),
    .clk_enable     (clk_enable),
    .instr          (instr),
    .ctrl           (ctrl),
    .data_readdata  (data_readdata),
    .zero           (zero),
    .commit         (commit),
    .active         (active),
    .instr_address  (instr_address),
    .data_address   (data_address),
    .data_writedata (data_writedata),
    .register_v0    (register_v0)
  );

endmodule

// File: test/mips_cpu_chk.sv
`timescale 1ns/1ns

module mips_cpu_chk (
  input logic        clk,
  input logic        arst_n,
  input logic        clk_enable,
  input logic        active,
  input logic [31:0] instr_address,
  input logic        data_write,
  input logic        data_read
);

  int unsigned fails = 0; // assertion failure count

  strobe_excl: assert property (@(posedge clk) disable iff (!arst_n)
    !(data_write && data_read))
    else begin
      fails++;
      $error("data_write and data_read high in the same cycle");
    end

  // no bus activity once the program has ended
  idle_quiet: assert property (@(posedge clk) disable iff (!arst_n)
    !active |-> !data_write && !data_read)
    else begin
      fails++;
      $error("memory strobe while inactive");
    end

  stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
    !clk_enable |=> $stable(instr_address)) // pc frozen on stall
    else begin
      fails++;
      $error("instr_address moved during a stall");
    end

endmodule

bind mips_cpu_harvard mips_cpu_chk u_chk (
  .clk           (clk),
  .arst_n        (arst_n),
  .clk_enable    (clk_enable),
  .active        (active),
  .instr_address (instr_address),
  .data_write    (data_write),
  .data_read     (data_read)
);

// File: test/mips_model.svh
`ifndef mips_model_svh
`define mips_model_svh

// instruction-set model state, advanced once per commit
logic [31:0] m_regs [32];
logic [31:0] m_ram [256];
logic [31:0] m_pc;
logic        m_active;

task automatic reset_model();
  for (int i = 0; i < 32; i++) begin
    m_regs[i] = '0;
  end
  m_pc     = reset_vector;
  m_active = 1'b1;
endtask

// forward-only program, r28 holds the data base, r25 is loaded with 0 for the last jr
task automatic gen_program();
  logic [31:0] r;
  logic [4:0]  rs;
  logic [4:0]  rt;
  logic [4:0]  dst;
  logic [15:0] off;
  int          kind;
  int          tgt;
  for (int i = 0; i < 256; i++) begin
    rom[i] = '0; // sll $0 encoding, decodes as no-op
  end
  rom[0] = {mips_pkg::op_ori, 5'd0, 5'd28, 16'h0040}; // base of the load/store window
  for (int i = 1; i < prog_len - 2; i++) begin
    kind = int'(lcg_next() % 32'd12);
    r    = lcg_next();
    rs   = {2'b00, r[2:0]};                // operands from r0..r7
    rt   = {2'b00, r[5:3]};
    dst  = r[6] ? 5'd2 : {2'b00, r[9:7]};  // half the writes go to v0, some to r0
    off  = {10'd0, r[13:10], 2'b00};       // 16 words at the base
    tgt  = i + 1 + int'(r[20:16]) % (prog_len - 2 - i); // never past the final lui
    case (kind)
      0: rom[i] = {mips_pkg::op_special, rs, rt, dst, 5'd0, mips_pkg::fn_addu};
      1: rom[i] = {mips_pkg::op_special, rs, rt, dst, 5'd0, mips_pkg::fn_subu};
      2: rom[i] = {mips_pkg::op_special, rs, rt, dst, 5'd0, mips_pkg::fn_and};
      3: rom[i] = {mips_pkg::op_special, rs, rt, dst, 5'd0, mips_pkg::fn_or};
      4: rom[i] = {mips_pkg::op_special, rs, rt, dst, 5'd0, mips_pkg::fn_slt};
      5: rom[i] = {mips_pkg::op_addiu, rs, dst, r[31:16]};
      6: rom[i] = {mips_pkg::op_ori, rs, dst, r[31:16]};
      7: rom[i] = {mips_pkg::op_lui, 5'd0, dst, r[31:16]};
      8: rom[i] = {mips_pkg::op_lw, 5'd28, dst, off};
      9: rom[i] = {mips_pkg::op_sw, 5'd28, rt, off};
      10: rom[i] = {(r[21] ? mips_pkg::op_bne : mips_pkg::op_beq), rs, rt, 16'(tgt - i - 1)};
      default: rom[i] = {mips_pkg::op_j, 26'((reset_vector >> 2) + 32'(tgt))};
    endcase
  end
  rom[prog_len - 2] = {mips_pkg::op_lui, 5'd0, 5'd25, 16'h0000};
  rom[prog_len - 1] = {mips_pkg::op_special, 5'd25, 5'd0, 5'd0, 5'd0, mips_pkg::fn_jr};
endtask

// one instruction at m_pc, no delay slot
task automatic step_model();
  logic [31:0] ins;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] sx;
  logic [31:0] nxt;
  logic [31:0] addr;
  logic [31:0] res;
  logic [4:0]  dst;
  logic        wr;
  ins  = rom[m_pc[9:2]];
  a    = m_regs[ins[25:21]];
  b    = m_regs[ins[20:16]];
  sx   = {{16{ins[15]}}, ins[15:0]};
  nxt  = m_pc + 32'd4;
  addr = a + sx;
  dst  = ins[20:16]; // rt unless register format
  wr   = 1'b0;
  res  = '0;
  case (ins[31:26])
    mips_pkg::op_special: begin
      dst = ins[15:11];
      wr  = 1'b1;
      case (ins[5:0])
        mips_pkg::fn_addu: res = a + b;
        mips_pkg::fn_subu: res = a - b;
        mips_pkg::fn_and:  res = a & b;
        mips_pkg::fn_or:   res = a | b;
        mips_pkg::fn_slt:  res = {31'd0, $signed(a) < $signed(b)};
        mips_pkg::fn_jr: begin
          wr  = 1'b0;
          nxt = a;
        end
        default: wr = 1'b0;
      endcase
    end
    mips_pkg::op_j: nxt = {nxt[31:28], ins[25:0], 2'b00};
    mips_pkg::op_beq: if (a == b) nxt = nxt + {sx[29:0], 2'b00};
    mips_pkg::op_bne: if (a != b) nxt = nxt + {sx[29:0], 2'b00};
    mips_pkg::op_addiu: begin
      wr  = 1'b1;
      res = a + sx;
    end
    mips_pkg::op_ori: begin
      wr  = 1'b1;
      res = a | {16'h0000, ins[15:0]};
    end
    mips_pkg::op_lui: begin
      wr  = 1'b1;
      res = {ins[15:0], 16'h0000};
    end
    mips_pkg::op_lw: begin
      wr  = 1'b1;
      res = m_ram[addr[9:2]];
    end
    mips_pkg::op_sw: m_ram[addr[9:2]] = b;
    default: ;
  endcase
  if (wr && dst != 5'd0) m_regs[dst] = res; // $zero stays zero
  m_pc = nxt;
  if (nxt == '0) m_active = 1'b0;
endtask

`endif

// File: test/mips_tb.sv
`timescale 1ns/1ns

module mips_tb;

  localparam logic [31:0] reset_vector = 32'hbfc0_0000;
  localparam int num_progs    = 6;
  localparam int prog_len     = 40; // words, last two end the program
  localparam int reset_cycles = 10;
  localparam int idle_cycles  = 8;  // watched after the jump to 0
  localparam int timeout_cycles =
    num_progs * (prog_len * 4 + reset_cycles + idle_cycles + 4);

  logic        clk;
  logic        arst_n;
  logic        clk_enable;
  logic        active;
  logic [31:0] register_v0;
  logic [31:0] instr_address;
  logic [31:0] instr_readdata;
  logic [31:0] data_address;
  logic        data_write;
  logic        data_read;
  logic [31:0] data_writedata;
  logic [31:0] data_readdata;
  logic [31:0] rom [256]; // instruction memory, low address bits
  logic [31:0] ram [256];
  logic [31:0] rng_state;
  int          errors;
  int          checks;
  int          cycle_count;

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return {rng_state[15:0], rng_state[31:16]}; // better bits at the bottom
  endfunction

  `include "mips_model.svh"

  mips_cpu_harvard #(
    .reset_vector (reset_vector)
  ) UUT (
    .clk            (clk),
    .arst_n         (arst_n),
    .clk_enable     (clk_enable),
    .active         (active),
    .register_v0    (register_v0),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_write     (data_write),
    .data_read      (data_read),
    .data_writedata (data_writedata),
    .data_readdata  (data_readdata)
  );

  assign instr_readdata = rom[instr_address[9:2]]; // combinational fetch
  assign data_readdata  = ram[data_address[9:2]];

  always @(posedge clk) begin
    if (data_write) ram[data_address[9:2]] <= data_writedata;
  end

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s: expected %h, got %h", name, exp, act);
    end
  endtask

  // same pattern in both copies, every address bit shows
  task automatic fill_ram();
    for (int i = 0; i < 256; i++) begin
      m_ram[i] = {8'hc3, i[7:0] ^ 8'h5a, ~i[7:0], i[7:0]};
      ram[i]  <= {8'hc3, i[7:0] ^ 8'h5a, ~i[7:0], i[7:0]};
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    arst_n     <= 1'b0;
    clk_enable <= 1'b0;
    repeat (reset_cycles) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    compare("instr_address", reset_vector, instr_address);
    compare("active", 32'd1, {31'd0, active});
    compare("data_write", 32'd0, {31'd0, data_write});
    compare("data_read", 32'd0, {31'd0, data_read});
  endtask

  // at negedge, before the edge that would commit
  task automatic check_cycle();
    logic [31:0] ins;
    logic        commit;
    logic        is_sw;
    logic        is_lw;
    ins    = rom[m_pc[9:2]];
    commit = m_active && clk_enable;
    is_sw  = commit && ins[31:26] == mips_pkg::op_sw;
    is_lw  = commit && ins[31:26] == mips_pkg::op_lw;
    compare("active", {31'd0, m_active}, {31'd0, active});
    compare("instr_address", m_pc, instr_address);
    compare("register_v0", m_regs[2], register_v0);
    compare("data_write", {31'd0, is_sw}, {31'd0, data_write}); // low on stall
    compare("data_read", {31'd0, is_lw}, {31'd0, data_read});
    if (is_sw || is_lw) begin
      compare("data_address", m_regs[ins[25:21]] + {{16{ins[15]}}, ins[15:0]}, data_address);
    end
    if (is_sw) compare("data_writedata", m_regs[ins[20:16]], data_writedata);
    if (commit) step_model();
  endtask

  task automatic run_program();
    int idle;
    idle = 0;
    while (idle < idle_cycles) begin
      @(posedge clk);
      clk_enable <= (lcg_next() % 32'd4) != 32'd0; // stall about one cycle in four
      @(negedge clk);
      check_cycle();
      if (!m_active) idle++;
    end
    for (int i = 0; i < 256; i++) begin
      compare($sformatf("ram[%0d]", i), m_ram[i], ram[i]);
    end
  endtask

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: programs did not finish within %0d cycles", timeout_cycles);
    $display("Test failed");
    $finish;
  end

  initial begin
    arst_n     = 1'b0;
    clk_enable = 1'b0;
    errors     = 0;
    checks     = 0;
    rng_state  = 32'h3d78_7481;
    for (int p = 0; p < num_progs; p++) begin
      gen_program();
      fill_ram();
      reset_model();
      apply_reset(); // also starts the next program
      run_program();
    end
    $display("checks %0d, errors %0d, assertion failures %0d",
             checks, errors, UUT.u_chk.fails);
    if (errors == 0 && UUT.u_chk.fails == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+test
logic/mips_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/controller.sv
logic/datapath.sv
logic/mips_cpu_harvard.sv
test/mips_cpu_chk.sv
test/mips_tb.sv

// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing --assert
SIM_FLAGS   = --binary --timing --assert -Wno-fatal
TOP         = mips_tb
FILELIST    = filelist.f
BUILD_DIR   = obj_dir
LOG         = sim.log
PASS_MSG    = Test passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
